// ==== common/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Memory port geometry
`define MEM_ADDR_W      32
`define MEM_DATA_W      32

// Words per cache line, one AXI beat each
`define MEM_LINE_WORDS  4

// Transaction ID width on all AXI channels
`define MEM_ID_W        4

`endif

// ==== common/mem_pkg.sv ====
`include "mem_defines.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    ////////////////////////////////////////
    // Channel payloads
    ////////////////////////////////////////

    // Shared by AW and AR
    typedef struct packed {
        logic [`MEM_ID_W-1:0]   id;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [3:0]             len;
        logic [2:0]             size;
        axi_burst_e             burst;
    } axi_addr_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0]   data;
        logic [`MEM_DATA_W/8-1:0] strb;
        logic                     last;
    } axi_wdata_t;

    typedef struct packed {
        logic [`MEM_ID_W-1:0] id;
        axi_resp_e            resp;
    } axi_bresp_t;

    typedef struct packed {
        logic [`MEM_ID_W-1:0]   id;
        logic [`MEM_DATA_W-1:0] data;
        axi_resp_e              resp;
        logic                   last;
    } axi_rdata_t;

    ////////////////////////////////////////
    // Client side
    ////////////////////////////////////////

    // Word 0 sits at the line base address
    typedef logic [`MEM_LINE_WORDS-1:0][`MEM_DATA_W-1:0] line_t;

    typedef struct packed {
        logic                   write;
        logic [`MEM_ADDR_W-1:0] addr;
        line_t                  wline;
    } mem_cmd_t;

endpackage

// ==== common/axi_chan_if.sv ====
`timescale 1ns/1ns

// Master modport is the AXI master side of the channel in every case,
// so for B and R it receives the payload and drives ready

interface axi_addr_if import mem_pkg::*; ();
    axi_addr_t data;
    logic      valid;
    logic      ready;

    modport master (output data, output valid, input ready);
    modport slave  (input data, input valid, output ready);
endinterface

interface axi_wdata_if import mem_pkg::*; ();
    axi_wdata_t data;
    logic       valid;
    logic       ready;

    modport master (output data, output valid, input ready);
    modport slave  (input data, input valid, output ready);
endinterface

interface axi_bresp_if import mem_pkg::*; ();
    axi_bresp_t data;
    logic       valid;
    logic       ready;

    modport master (input data, input valid, output ready);
    modport slave  (output data, output valid, input ready);
endinterface

interface axi_rdata_if import mem_pkg::*; ();
    axi_rdata_t data;
    logic       valid;
    logic       ready;

    modport master (input data, input valid, output ready);
    modport slave  (output data, output valid, input ready);
endinterface

// ==== axi_bridge/axi_reg_slice.sv ====
`timescale 1ns/1ns

// Two-entry skid buffer, both directions registered
module axi_reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t skid_data;
    logic     skid_valid;
    logic     rdy_en;
    logic     out_free;

    // Ready comes only from flops; held low until the first edge after reset
    assign in_ready = rdy_en & ~skid_valid;
    assign out_free = ~out_valid | out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdy_en     <= 1'b0;
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            rdy_en <= 1'b1;
            if (out_free) begin
                // Drain the skid entry first, else pass the input through
                out_valid  <= skid_valid | (in_valid & in_ready);
                skid_valid <= 1'b0;
            end else if (in_valid && in_ready) begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end else if (in_ready) begin
            skid_data <= in_data;
        end
    end

endmodule

// ==== axi_bridge/axi_port_bridge.sv ====
`timescale 1ns/1ns
`include "mem_defines.svh"

module axi_port_bridge import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,

    axi_addr_if.slave                aw,
    axi_wdata_if.slave               w,
    axi_bresp_if.slave               b,
    axi_addr_if.slave                ar,
    axi_rdata_if.slave               r,

    output logic [`MEM_ID_W-1:0]     s_axi_awid,
    output logic [`MEM_ADDR_W-1:0]   s_axi_awaddr,
    output logic [7:0]               s_axi_awlen,
    output logic [2:0]               s_axi_awsize,
    output logic [1:0]               s_axi_awburst,
    output logic                     s_axi_awvalid,
    input  logic                     s_axi_awready,

    output logic [`MEM_DATA_W-1:0]   s_axi_wdata,
    output logic [`MEM_DATA_W/8-1:0] s_axi_wstrb,
    output logic                     s_axi_wlast,
    output logic                     s_axi_wvalid,
    input  logic                     s_axi_wready,

    input  logic [`MEM_ID_W-1:0]     s_axi_bid,
    input  logic [1:0]               s_axi_bresp,
    input  logic                     s_axi_bvalid,
    output logic                     s_axi_bready,

    output logic [`MEM_ID_W-1:0]     s_axi_arid,
    output logic [`MEM_ADDR_W-1:0]   s_axi_araddr,
    output logic [7:0]               s_axi_arlen,
    output logic [2:0]               s_axi_arsize,
    output logic [1:0]               s_axi_arburst,
    output logic                     s_axi_arvalid,
    input  logic                     s_axi_arready,

    input  logic [`MEM_ID_W-1:0]     s_axi_rid,
    input  logic [`MEM_DATA_W-1:0]   s_axi_rdata,
    input  logic [1:0]               s_axi_rresp,
    input  logic                     s_axi_rlast,
    input  logic                     s_axi_rvalid,
    output logic                     s_axi_rready
);

    axi_addr_t  aw_q;
    axi_addr_t  ar_q;
    axi_wdata_t w_q;
    axi_bresp_t b_in;
    axi_rdata_t r_in;

    ////////////////////////////////////////
    // Outbound channels
    ////////////////////////////////////////

    axi_reg_slice #(.payload_t(axi_addr_t)) u_aw_slice (
        .clk, .arst_n,
        .in_data   (aw.data),
        .in_valid  (aw.valid),
        .in_ready  (aw.ready),
        .out_data  (aw_q),
        .out_valid (s_axi_awvalid),
        .out_ready (s_axi_awready)
    );

    // Length widened to AXI4 with zero upper bits
    assign s_axi_awid    = aw_q.id;
    assign s_axi_awaddr  = aw_q.addr;
    assign s_axi_awlen   = {4'h0, aw_q.len};
    assign s_axi_awsize  = aw_q.size;
    assign s_axi_awburst = aw_q.burst;

    axi_reg_slice #(.payload_t(axi_wdata_t)) u_w_slice (
        .clk, .arst_n,
        .in_data   (w.data),
        .in_valid  (w.valid),
        .in_ready  (w.ready),
        .out_data  (w_q),
        .out_valid (s_axi_wvalid),
        .out_ready (s_axi_wready)
    );

    assign s_axi_wdata = w_q.data;
    assign s_axi_wstrb = w_q.strb;
    assign s_axi_wlast = w_q.last;

    axi_reg_slice #(.payload_t(axi_addr_t)) u_ar_slice (
        .clk, .arst_n,
        .in_data   (ar.data),
        .in_valid  (ar.valid),
        .in_ready  (ar.ready),
        .out_data  (ar_q),
        .out_valid (s_axi_arvalid),
        .out_ready (s_axi_arready)
    );

    assign s_axi_arid    = ar_q.id;
    assign s_axi_araddr  = ar_q.addr;
    assign s_axi_arlen   = {4'h0, ar_q.len};
    assign s_axi_arsize  = ar_q.size;
    assign s_axi_arburst = ar_q.burst;

    ////////////////////////////////////////
    // Inbound channels
    ////////////////////////////////////////

    assign b_in = '{id: s_axi_bid, resp: axi_resp_e'(s_axi_bresp)};

    axi_reg_slice #(.payload_t(axi_bresp_t)) u_b_slice (
        .clk, .arst_n,
        .in_data   (b_in),
        .in_valid  (s_axi_bvalid),
        .in_ready  (s_axi_bready),
        .out_data  (b.data),
        .out_valid (b.valid),
        .out_ready (b.ready)
    );

    assign r_in = '{
        id:   s_axi_rid,
        data: s_axi_rdata,
        resp: axi_resp_e'(s_axi_rresp),
        last: s_axi_rlast
    };

    axi_reg_slice #(.payload_t(axi_rdata_t)) u_r_slice (
        .clk, .arst_n,
        .in_data   (r_in),
        .in_valid  (s_axi_rvalid),
        .in_ready  (s_axi_rready),
        .out_data  (r.data),
        .out_valid (r.valid),
        .out_ready (r.ready)
    );

endmodule

// ==== line_engine/line_xfer_engine.sv ====
`timescale 1ns/1ns
`include "mem_defines.svh"

module line_xfer_engine import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  logic                   cmd_write,
    input  logic [`MEM_ADDR_W-1:0] cmd_addr,
    input  line_t                  cmd_wline,

    output logic                   rsp_valid,
    output logic                   rsp_err,
    output line_t                  rsp_rline,

    axi_addr_if.master             aw,
    axi_wdata_if.master            w,
    axi_bresp_if.master            b,
    axi_addr_if.master             ar,
    axi_rdata_if.master            r
);

    localparam int BEAT_W = $clog2(`MEM_LINE_WORDS);
    localparam int OFS_W  = $clog2(`MEM_LINE_WORDS * `MEM_DATA_W / 8);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`MEM_LINE_WORDS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WRITE,
        S_BRESP,
        S_RADDR,
        S_RDATA
    } state_e;

    state_e               state;
    mem_cmd_t             cmd_q;
    logic [`MEM_ID_W-1:0] id_q;
    logic [BEAT_W-1:0]    beat_q;
    logic                 aw_done;
    logic                 w_done;
    logic                 err_q;
    line_t                rline_q;
    axi_addr_t            line_req;
    logic                 cmd_hs, aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic                 b_bad, r_bad;

    assign cmd_hs = cmd_valid & cmd_ready;
    assign aw_hs  = aw.valid & aw.ready;
    assign w_hs   = w.valid & w.ready;
    assign b_hs   = b.valid & b.ready;
    assign ar_hs  = ar.valid & ar.ready;
    assign r_hs   = r.valid & r.ready;

    ////////////////////////////////////////
    // Channel drive
    ////////////////////////////////////////

    // One full INCR line burst, base aligned to the line
    assign line_req = '{
        id:    id_q,
        addr:  {cmd_q.addr[`MEM_ADDR_W-1:OFS_W], OFS_W'(0)},
        len:   4'(`MEM_LINE_WORDS - 1),
        size:  3'($clog2(`MEM_DATA_W / 8)),
        burst: BURST_INCR
    };

    assign cmd_ready = (state == S_IDLE);

    assign aw.data  = line_req;
    assign aw.valid = (state == S_WRITE) && !aw_done;
    assign ar.data  = line_req;
    assign ar.valid = (state == S_RADDR);

    assign w.data  = '{data: cmd_q.wline[beat_q], strb: '1, last: beat_q == LAST_BEAT};
    assign w.valid = (state == S_WRITE) && !w_done;

    assign b.ready = (state == S_BRESP);
    assign r.ready = (state == S_RDATA);

    // Wrong ID, non-OKAY response or misplaced last
    assign b_bad = (b.data.id != id_q) || (b.data.resp != RESP_OKAY);
    assign r_bad = (r.data.id != id_q) || (r.data.resp != RESP_OKAY) ||
                   (r.data.last != (beat_q == LAST_BEAT));

    assign rsp_rline = rline_q;

    ////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            id_q      <= '0;
            beat_q    <= '0;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            err_q     <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_err   <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd_hs) begin
                        id_q    <= id_q + 1'b1;
                        beat_q  <= '0;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        err_q   <= 1'b0;
                        state   <= cmd_write ? S_WRITE : S_RADDR;
                    end
                end
                S_WRITE: begin
                    // Address and data run independently
                    if (aw_hs) begin
                        aw_done <= 1'b1;
                    end
                    if (w_hs) begin
                        beat_q <= beat_q + 1'b1;
                        if (w.data.last) begin
                            w_done <= 1'b1;
                        end
                    end
                    if ((aw_done || aw_hs) && (w_done || (w_hs && w.data.last))) begin
                        state <= S_BRESP;
                    end
                end
                S_BRESP: begin
                    if (b_hs) begin
                        rsp_valid <= 1'b1;
                        rsp_err   <= b_bad;
                        state     <= S_IDLE;
                    end
                end
                S_RADDR: begin
                    if (ar_hs) begin
                        state <= S_RDATA;
                    end
                end
                S_RDATA: begin
                    if (r_hs) begin
                        beat_q <= beat_q + 1'b1;
                        err_q  <= err_q | r_bad;
                        if (r.data.last) begin
                            rsp_valid <= 1'b1;
                            rsp_err   <= err_q | r_bad;
                            state     <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Command and read line storage
    always_ff @(posedge clk) begin
        if (cmd_hs) begin
            cmd_q <= '{write: cmd_write, addr: cmd_addr, wline: cmd_wline};
        end
        if (r_hs) begin
            rline_q[beat_q] <= r.data.data;
        end
    end

endmodule

// ==== logic/mem_subsys_top.sv ====
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_subsys_top import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,

    // Client command and response
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  logic                     cmd_write,
    input  logic [`MEM_ADDR_W-1:0]   cmd_addr,
    input  line_t                    cmd_wline,
    output logic                     rsp_valid,
    output logic                     rsp_err,
    output line_t                    rsp_rline,

    // AXI4 toward the block-RAM controller
    output logic [`MEM_ID_W-1:0]     s_axi_awid,
    output logic [`MEM_ADDR_W-1:0]   s_axi_awaddr,
    output logic [7:0]               s_axi_awlen,
    output logic [2:0]               s_axi_awsize,
    output logic [1:0]               s_axi_awburst,
    output logic                     s_axi_awvalid,
    input  logic                     s_axi_awready,

    output logic [`MEM_DATA_W-1:0]   s_axi_wdata,
    output logic [`MEM_DATA_W/8-1:0] s_axi_wstrb,
    output logic                     s_axi_wlast,
    output logic                     s_axi_wvalid,
    input  logic                     s_axi_wready,

    input  logic [`MEM_ID_W-1:0]     s_axi_bid,
    input  logic [1:0]               s_axi_bresp,
    input  logic                     s_axi_bvalid,
    output logic                     s_axi_bready,

    output logic [`MEM_ID_W-1:0]     s_axi_arid,
    output logic [`MEM_ADDR_W-1:0]   s_axi_araddr,
    output logic [7:0]               s_axi_arlen,
    output logic [2:0]               s_axi_arsize,
    output logic [1:0]               s_axi_arburst,
    output logic                     s_axi_arvalid,
    input  logic                     s_axi_arready,

    input  logic [`MEM_ID_W-1:0]     s_axi_rid,
    input  logic [`MEM_DATA_W-1:0]   s_axi_rdata,
    input  logic [1:0]               s_axi_rresp,
    input  logic                     s_axi_rlast,
    input  logic                     s_axi_rvalid,
    output logic                     s_axi_rready
);

    // Internal channels between engine and bridge
    axi_addr_if  aw ();
    axi_wdata_if w ();
    axi_bresp_if b ();
    axi_addr_if  ar ();
    axi_rdata_if r ();

    line_xfer_engine u_engine (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wline (cmd_wline),
        .rsp_valid (rsp_valid),
        .rsp_err   (rsp_err),
        .rsp_rline (rsp_rline),
        .aw        (aw.master),
        .w         (w.master),
        .b         (b.master),
        .ar        (ar.master),
        .r         (r.master)
    );

    // Flat AXI4 ports share names with the bridge ports
    axi_port_bridge u_bridge (
        .aw (aw.slave),
        .w  (w.slave),
        .b  (b.slave),
        .ar (ar.slave),
        .r  (r.slave),
        .*
    );

endmodule

// ==== dv/axi_mem_model.sv ====
`timescale 1ns/1ns
`include "mem_defines.svh"

// Behavioral AXI4 slave standing in for the block-RAM controller
module axi_mem_model (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic [`MEM_ID_W-1:0]     s_axi_awid,
    input  logic [`MEM_ADDR_W-1:0]   s_axi_awaddr,
    input  logic [7:0]               s_axi_awlen,
    input  logic [2:0]               s_axi_awsize,
    input  logic [1:0]               s_axi_awburst,
    input  logic                     s_axi_awvalid,
    output logic                     s_axi_awready,

    input  logic [`MEM_DATA_W-1:0]   s_axi_wdata,
    input  logic [`MEM_DATA_W/8-1:0] s_axi_wstrb,
    input  logic                     s_axi_wlast,
    input  logic                     s_axi_wvalid,
    output logic                     s_axi_wready,

    output logic [`MEM_ID_W-1:0]     s_axi_bid,
    output logic [1:0]               s_axi_bresp,
    output logic                     s_axi_bvalid,
    input  logic                     s_axi_bready,

    input  logic [`MEM_ID_W-1:0]     s_axi_arid,
    input  logic [`MEM_ADDR_W-1:0]   s_axi_araddr,
    input  logic [7:0]               s_axi_arlen,
    input  logic [2:0]               s_axi_arsize,
    input  logic [1:0]               s_axi_arburst,
    input  logic                     s_axi_arvalid,
    output logic                     s_axi_arready,

    output logic [`MEM_ID_W-1:0]     s_axi_rid,
    output logic [`MEM_DATA_W-1:0]   s_axi_rdata,
    output logic [1:0]               s_axi_rresp,
    output logic                     s_axi_rlast,
    output logic                     s_axi_rvalid,
    input  logic                     s_axi_rready
);

    // 64 KB window of 32-bit words
    logic [`MEM_DATA_W-1:0] mem [0:16383];
    logic [31:0]            lcg_state = 32'h43e78fa2;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Ready or valid offered in about three cycles of four
    function automatic logic stall_free();
        logic [31:0] v;
        v = lcg_next();
        return v[17:16] != 2'b00;
    endfunction

    // Top 1 KB of the window answers SLVERR
    function automatic logic in_err_range(input logic [`MEM_ADDR_W-1:0] addr);
        return addr[15:10] == 6'h3f;
    endfunction

    // Only full-word INCR bursts are served
    function automatic logic full_word_incr(input logic [1:0] burst, input logic [2:0] size);
        return (burst == 2'b01) && ((1 << size) == `MEM_DATA_W / 8);
    endfunction

    initial begin
        for (int k = 0; k < 16384; k++) begin
            mem[k] = k ^ 32'ha5a50000;
        end
    end

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    initial begin : write_side
        logic [`MEM_ID_W-1:0] wid;
        logic [13:0]          widx;
        logic                 werr;
        logic                 done;
        int                   beat;
        int                   wlen;
        s_axi_awready = 1'b0;
        s_axi_wready  = 1'b0;
        s_axi_bvalid  = 1'b0;
        s_axi_bid     = '0;
        s_axi_bresp   = 2'b00;
        @(negedge clk);
        while (!arst_n) @(negedge clk);
        forever begin
            s_axi_awready = stall_free();
            @(posedge clk);
            if (s_axi_awvalid && s_axi_awready) begin
                wid  = s_axi_awid;
                widx = s_axi_awaddr[15:2];
                wlen = int'(s_axi_awlen);
                werr = in_err_range(s_axi_awaddr) ||
                       !full_word_incr(s_axi_awburst, s_axi_awsize);
                beat = 0;
                done = 1'b0;
                @(negedge clk);
                s_axi_awready = 1'b0;
                // Data beats only after the address
                do begin
                    s_axi_wready = stall_free();
                    @(posedge clk);
                    if (s_axi_wvalid && s_axi_wready) begin
                        // Last must sit on the beat the length names
                        if (s_axi_wlast != (beat == wlen)) begin
                            werr = 1'b1;
                        end
                        if (!werr) begin
                            for (int b = 0; b < `MEM_DATA_W / 8; b++) begin
                                if (s_axi_wstrb[b]) begin
                                    mem[widx + 14'(beat)][8*b +: 8] = s_axi_wdata[8*b +: 8];
                                end
                            end
                        end
                        beat = beat + 1;
                        done = s_axi_wlast;
                    end
                    @(negedge clk);
                end while (!done);
                s_axi_wready = 1'b0;
                s_axi_bvalid = 1'b1;
                s_axi_bid    = wid;
                s_axi_bresp  = werr ? 2'b10 : 2'b00;
                do @(posedge clk); while (!s_axi_bready);
                @(negedge clk);
                s_axi_bvalid = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    initial begin : read_side
        logic [`MEM_ID_W-1:0] rid;
        logic [13:0]          ridx;
        logic                 rerr;
        int                   rlen;
        s_axi_arready = 1'b0;
        s_axi_rvalid  = 1'b0;
        s_axi_rid     = '0;
        s_axi_rdata   = '0;
        s_axi_rresp   = 2'b00;
        s_axi_rlast   = 1'b0;
        @(negedge clk);
        while (!arst_n) @(negedge clk);
        forever begin
            s_axi_arready = stall_free();
            @(posedge clk);
            if (s_axi_arvalid && s_axi_arready) begin
                rid  = s_axi_arid;
                ridx = s_axi_araddr[15:2];
                rerr = in_err_range(s_axi_araddr) ||
                       !full_word_incr(s_axi_arburst, s_axi_arsize);
                rlen = int'(s_axi_arlen);
                @(negedge clk);
                s_axi_arready = 1'b0;
                for (int i = 0; i <= rlen; i++) begin
                    // Random gap before each beat
                    while (!stall_free()) begin
                        s_axi_rvalid = 1'b0;
                        @(negedge clk);
                    end
                    s_axi_rvalid = 1'b1;
                    s_axi_rid    = rid;
                    s_axi_rdata  = mem[ridx + 14'(i)];
                    s_axi_rresp  = rerr ? 2'b10 : 2'b00;
                    s_axi_rlast  = (i == rlen);
                    do @(posedge clk); while (!s_axi_rready);
                    @(negedge clk);
                end
                s_axi_rvalid = 1'b0;
                s_axi_rlast  = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

endmodule

// ==== dv/mem_subsys_sva.sv ====
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_subsys_sva (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   cmd_ready,
    input logic                   rsp_valid,
    input logic [`MEM_ID_W-1:0]   s_axi_awid,
    input logic [`MEM_ADDR_W-1:0] s_axi_awaddr,
    input logic [7:0]             s_axi_awlen,
    input logic                   s_axi_awvalid,
    input logic                   s_axi_awready,
    input logic [`MEM_DATA_W-1:0] s_axi_wdata,
    input logic                   s_axi_wlast,
    input logic                   s_axi_wvalid,
    input logic                   s_axi_wready,
    input logic [`MEM_ID_W-1:0]   s_axi_arid,
    input logic [`MEM_ADDR_W-1:0] s_axi_araddr,
    input logic [7:0]             s_axi_arlen,
    input logic                   s_axi_arvalid,
    input logic                   s_axi_arready
);

    // Valid and payload hold until the beat is taken
    aw_stable: assert property (@(posedge clk) disable iff (!arst_n)
        s_axi_awvalid && !s_axi_awready |=>
        s_axi_awvalid && $stable({s_axi_awid, s_axi_awaddr, s_axi_awlen}))
        else $error("AW changed before handshake");

    w_stable: assert property (@(posedge clk) disable iff (!arst_n)
        s_axi_wvalid && !s_axi_wready |=>
        s_axi_wvalid && $stable({s_axi_wdata, s_axi_wlast}))
        else $error("W changed before handshake");

    ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
        s_axi_arvalid && !s_axi_arready |=>
        s_axi_arvalid && $stable({s_axi_arid, s_axi_araddr, s_axi_arlen}))
        else $error("AR changed before handshake");

    rsp_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid held for two cycles");

    ready_after_reset: assert property (@(posedge clk)
        arst_n && !$past(arst_n) |-> cmd_ready)
        else $error("cmd_ready low in first cycle after reset");

endmodule

bind mem_subsys_top mem_subsys_sva u_sva (.*);

// ==== dv/tb_mem_subsys.sv ====
`timescale 1ns/1ns
`include "mem_defines.svh"

module tb_mem_subsys import mem_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 500;
    localparam int MAX_ROWS       = 32;

    logic                     clk;
    logic                     arst_n;
    logic                     cmd_valid;
    logic                     cmd_ready;
    logic                     cmd_write;
    logic [`MEM_ADDR_W-1:0]   cmd_addr;
    line_t                    cmd_wline;
    logic                     rsp_valid;
    logic                     rsp_err;
    line_t                    rsp_rline;

    logic [`MEM_ID_W-1:0]     s_axi_awid, s_axi_bid, s_axi_arid, s_axi_rid;
    logic [`MEM_ADDR_W-1:0]   s_axi_awaddr, s_axi_araddr;
    logic [7:0]               s_axi_awlen, s_axi_arlen;
    logic [2:0]               s_axi_awsize, s_axi_arsize;
    logic [1:0]               s_axi_awburst, s_axi_arburst, s_axi_bresp, s_axi_rresp;
    logic                     s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
    logic                     s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
    logic                     s_axi_rvalid, s_axi_rready, s_axi_wlast, s_axi_rlast;
    logic [`MEM_DATA_W-1:0]   s_axi_wdata, s_axi_rdata;
    logic [`MEM_DATA_W/8-1:0] s_axi_wstrb;

    // Command table
    logic                   row_write [MAX_ROWS];
    logic [`MEM_ADDR_W-1:0] row_addr  [MAX_ROWS];
    line_t                  row_wline [MAX_ROWS];
    logic                   row_err   [MAX_ROWS];
    line_t                  row_rline [MAX_ROWS];
    int                     num_rows;
    int                     rsp_count;
    logic [31:0]            rand_state;

    mem_subsys_top DUT (.*);
    axi_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Word k of the memory starts out as k xor A5A50000
    function automatic line_t initial_line(input logic [`MEM_ADDR_W-1:0] addr);
        line_t l;
        for (int k = 0; k < `MEM_LINE_WORDS; k++) begin
            l[k] = {18'b0, addr[15:2] + 14'(k)} ^ 32'ha5a50000;
        end
        return l;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int k = 0; k < `MEM_LINE_WORDS; k++) begin
            l[k] = next_rand();
        end
        return l;
    endfunction

    task automatic add_row(input logic wr, input logic [`MEM_ADDR_W-1:0] addr,
                           input line_t wl, input logic err, input line_t rl);
        row_write[num_rows] = wr;
        row_addr[num_rows]  = addr;
        row_wline[num_rows] = wl;
        row_err[num_rows]   = err;
        row_rline[num_rows] = rl;
        num_rows++;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
            abort_run("First mismatch ends the run");
        end
    endtask

    // Issue one command and wait for its response strobe
    task automatic run_row(input int i);
        int cycles;
        cmd_valid = 1'b1;
        cmd_write = row_write[i];
        cmd_addr  = row_addr[i];
        cmd_wline = row_wline[i];
        cycles    = 0;
        while (!cmd_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run($sformatf("Timed out waiting for cmd_ready on row %0d", i));
            end
        end
        // Accepted on the rising edge in between
        @(negedge clk);
        cmd_valid = 1'b0;
        cycles    = 0;
        while (!rsp_valid) begin
            check_value($sformatf("row %0d cmd_ready while busy", i), cmd_ready, 0);
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run($sformatf("Timed out waiting for rsp_valid on row %0d", i));
            end
        end
        check_value($sformatf("row %0d rsp_err", i), rsp_err, row_err[i]);
        if (!row_write[i]) begin
            check_value($sformatf("row %0d rsp_rline", i), rsp_rline, row_rline[i]);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && rsp_valid) begin
            rsp_count <= rsp_count + 1;
        end
    end

    initial begin
        line_t l1;
        line_t l2;
        line_t l3;
        line_t l4;
        arst_n     = 1'b0;
        cmd_valid  = 1'b0;
        cmd_write  = 1'b0;
        cmd_addr   = '0;
        cmd_wline  = '0;
        rsp_count  = 0;
        num_rows   = 0;
        rand_state = 32'h43e78fa2;
        l1 = random_line();
        l2 = random_line();
        l3 = random_line();
        l4 = random_line();

        // Untouched line, then write and read back with neighbors
        add_row(0, 32'h0000_0100, '0, 0, initial_line(32'h0000_0100));
        add_row(1, 32'h0000_0200, l1, 0, '0);
        add_row(0, 32'h0000_0200, '0, 0, l1);
        add_row(0, 32'h0000_01f0, '0, 0, initial_line(32'h0000_01f0));
        add_row(0, 32'h0000_0210, '0, 0, initial_line(32'h0000_0210));
        // Adjacent lines back to back
        add_row(1, 32'h0000_03f0, l2, 0, '0);
        add_row(1, 32'h0000_0400, l3, 0, '0);
        add_row(0, 32'h0000_03f0, '0, 0, l2);
        add_row(0, 32'h0000_0400, '0, 0, l3);
        // Error range in the top 1 KB
        add_row(1, 32'h0000_fc00, l4, 1, '0);
        add_row(0, 32'h0000_fc00, '0, 1, initial_line(32'h0000_fc00));
        add_row(0, 32'h0000_fbf0, '0, 0, initial_line(32'h0000_fbf0));
        add_row(0, 32'h0000_fff0, '0, 1, initial_line(32'h0000_fff0));
        add_row(1, 32'h0000_0200, l4, 0, '0);
        add_row(0, 32'h0000_0200, '0, 0, l4);

        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        @(negedge clk);
        check_value("response count", 128'(rsp_count), 128'(num_rows));
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/mem_pkg.sv
common/axi_chan_if.sv
axi_bridge/axi_reg_slice.sv
axi_bridge/axi_port_bridge.sv
line_engine/line_xfer_engine.sv
logic/mem_subsys_top.sv
dv/axi_mem_model.sv
dv/mem_subsys_sva.sv
dv/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator build for the memory subsystem testbench

VERILATOR  ?= verilator
TOP        ?= tb_mem_subsys
RTL_TOP    ?= mem_subsys_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert -Wall
SIM_ARGS   ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
